// File: verilog/rsStatsPkg.sv
package rsStatsPkg;

    // One decoder result per codeword
    typedef struct packed {
        logic [7:0] errors;                     // Symbols corrected in this codeword
        logic       fail;                       // Codeword could not be corrected
    } cwResultT;

    // One summary per interleaved frame
    typedef struct packed {
        logic [11:0] errSum;                    // Corrected symbols of good codewords
        logic        failed;                    // At least one codeword failed
    } frameSumT;

    // Control register, low half of word 0
    typedef struct packed {
        logic [7:0] fill;                       // Virtual fill Q, only stored for the decoder
        logic [3:0] interleave;                 // Interleave depth I
        logic [2:0] spare;                      // Reads back what was written
        logic       rIndex;                     // 1 selects RS(255,223), 0 RS(255,239)
    } rsCtrlT;

    // Status register, word 1, cleared by reading it
    typedef struct packed {
        logic [7:0]  failCnt;                   // Failed frames
        logic [7:0]  frameCnt;                  // Frames seen since last read
        logic [15:0] errCnt;                    // Corrected symbols since last read
    } statusT;

    // Word addresses within the 5 bit byte address
    localparam logic [2:0] ctrlAddr   = 3'd0;
    localparam logic [2:0] statusAddr = 3'd1;

    // Depth 1, RS(255,239), no fill
    localparam rsCtrlT ctrlReset = 16'h0010;

    // Correction capability per rIndex setting
    localparam logic [7:0] eRs239 = 8'd8;
    localparam logic [7:0] eRs223 = 8'd16;

    // Deepest interleave the assembler supports
    localparam logic [3:0] maxDepth = 4'd8;

    // Default number of summaries held while a status read is in progress
    localparam int fifoDepth = 4;

endpackage

// File: verilog/rsFrameAssembler.sv
module rsFrameAssembler (
    input  logic                busClk,
    input  logic                rstN,
    input  logic                cwValid,       // One strobe per decoded codeword
    input  rsStatsPkg::cwResultT cwResult,
    input  rsStatsPkg::rsCtrlT  control,
    output logic                sumValid,      // One strobe per finished frame
    output rsStatsPkg::frameSumT sumData
);
    import rsStatsPkg::*;

    logic [3:0]  cwCnt;                         // Codewords already in the current frame
    logic [3:0]  depthLat;                      // Depth latched at frame start
    logic [3:0]  frameDepth;                    // Depth that applies to this codeword
    logic [11:0] errAcc;                        // Running error sum of the frame
    logic        failAcc;                       // Running fail flag of the frame
    logic [11:0] accBase;                       // Sum to add onto, zero at frame start
    logic        failBase;
    logic [7:0]  cwErr;                         // Errors that count toward the sum
    logic [12:0] sumWide;                       // One spare bit to catch overflow
    logic        frameStart;
    logic        lastCw;

    // Only the CCSDS depths are legal, anything else runs as depth 1
    function automatic logic [3:0] decodeDepth(input logic [3:0] depthIn);
        logic [3:0] depthOut;
        case (depthIn)
            4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd8: depthOut = depthIn;
            default:                             depthOut = 4'd1;
        endcase
        return depthOut;
    endfunction

    assign frameStart = (cwCnt == 4'd0);
    assign frameDepth = frameStart ? decodeDepth(control.interleave) : depthLat;
    assign lastCw     = cwValid && (cwCnt + 4'd1 == frameDepth);

    // A failed codeword has no meaningful correction count
    assign cwErr    = cwResult.fail ? 8'd0 : cwResult.errors;
    assign accBase  = frameStart ? 12'd0 : errAcc;
    assign failBase = frameStart ? 1'b0 : failAcc;
    assign sumWide  = {1'b0, accBase} + {5'd0, cwErr};

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            cwCnt    <= 4'd0;
            sumValid <= 1'b0;
        end else begin
            sumValid <= lastCw;                 // Summary leaves one cycle after last codeword
            if (cwValid) begin
                if (lastCw) begin
                    cwCnt <= 4'd0;              // Next codeword opens a new frame
                end else begin
                    cwCnt <= cwCnt + 4'd1;
                end
            end
        end
    end

    // Frame payload, meaningful only while a frame is open
    always_ff @(posedge busClk) begin
        if (cwValid) begin
            errAcc  <= sumWide[11:0];
            failAcc <= failBase | cwResult.fail;
            if (frameStart) begin
                depthLat <= frameDepth;         // Depth changes mid-frame are ignored
            end
        end
        if (lastCw) begin
            sumData.errSum <= sumWide[11:0];
            sumData.failed <= failBase | cwResult.fail;
        end
    end

    // Decoder must stay within its correction capability E
    assert property (@(posedge busClk) disable iff (!rstN)
        cwValid && !cwResult.fail |->
            cwResult.errors <= (control.rIndex ? eRs223 : eRs239))
        else $error("Codeword reports more corrections than E allows");

    // Depth at most 8 keeps the frame sum inside 12 bits
    assert property (@(posedge busClk) disable iff (!rstN)
        cwValid |-> !sumWide[12] && frameDepth <= maxDepth)
        else $error("Frame error sum overflowed");

endmodule

// File: verilog/rsSummaryFifo.sv
module rsSummaryFifo #(
    parameter type payloadT = logic [7:0],
    parameter int  depth    = 4
) (
    input  logic    busClk,
    input  logic    rstN,
    input  logic    pushValid,                  // Strobe, must be taken or dropped
    input  payloadT pushData,
    input  logic    holdStats,                  // Freeze popping during a status read
    output logic    popValid,
    output payloadT popData,
    output logic    overflow                    // Sticky until reset
);
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payloadT         mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            empty;
    logic            full;
    logic            doPush;
    logic            doPop;

    assign empty  = (count == '0);
    assign full   = (count == cntW'(depth));
    assign doPush = pushValid && !full;
    assign doPop  = !holdStats && !empty;       // One stored entry per cycle

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        logic [ptrW-1:0] result;
        if (ptr == ptrW'(depth - 1)) begin
            result = '0;                        // Wrap, depth need not be a power of two
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            popValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            popValid <= doPop;
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + cntW'(doPush) - cntW'(doPop);
            if (pushValid && full) begin
                overflow <= 1'b1;               // Summary lost
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
        if (doPop) begin
            popData <= mem[rdPtr];
        end
    end

    assert property (@(posedge busClk) disable iff (!rstN) count <= cntW'(depth))
        else $error("FIFO count above depth");

endmodule

// File: verilog/rsStatsCounters.sv
module rsStatsCounters (
    input  logic                 busClk,
    input  logic                 rstN,
    input  logic                 popValid,     // One frame summary
    input  rsStatsPkg::frameSumT popData,
    input  logic                 statusRead,   // Clear after the bus read the status
    output rsStatsPkg::statusT   status
);
    import rsStatsPkg::*;

    statusT      statusNxt;
    logic [16:0] errWide;                       // Carry out means errCnt saturates

    assign errWide = {1'b0, status.errCnt} + 17'(popData.errSum);

    always_comb begin
        statusNxt = status;
        if (status.frameCnt != 8'hFF) begin
            statusNxt.frameCnt = status.frameCnt + 8'd1;
        end
        if (popData.failed && (status.failCnt != 8'hFF)) begin
            statusNxt.failCnt = status.failCnt + 8'd1;
        end
        statusNxt.errCnt = errWide[16] ? 16'hFFFF : errWide[15:0];
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            status <= '0;
        end else if (statusRead) begin
            status <= '0;                       // Clear beats a pop in the same cycle
        end else if (popValid) begin
            status <= statusNxt;
        end
    end

    // Counters only move down through a status read or reset
    assert property (@(posedge busClk) disable iff (!rstN)
        !statusRead |=>
            (status.failCnt  >= $past(status.failCnt))  &&
            (status.frameCnt >= $past(status.frameCnt)) &&
            (status.errCnt   >= $past(status.errCnt)))
        else $error("Status counter decreased without a read");

    // The hold on the FIFO keeps pops away from the clear
    assert property (@(posedge busClk) disable iff (!rstN)
        statusRead |-> !popValid)
        else $error("Frame summary lost to a status clear");

endmodule

// File: verilog/rsRegs.sv
module rsRegs (
    input  logic               busClk,
    input  logic               rstN,
    input  logic               cs,             // Held for the whole access
    input  logic [4:0]         addr,           // Byte address
    input  logic [31:0]        dataIn,
    input  logic [3:0]         byteEn,         // Per-lane write enables
    input  rsStatsPkg::statusT status,
    output logic [31:0]        dataOut,
    output rsStatsPkg::rsCtrlT control,
    output logic               statusRead,     // One cycle when cs drops after status access
    output logic               holdStats       // Status access in progress
);
    import rsStatsPkg::*;

    logic [2:0] wordAddr;
    logic       ctrlSel;
    logic       statusSel;
    logic       statusSeen;                    // Status was addressed during this cs

    assign wordAddr  = addr[4:2];              // Byte offset ignored
    assign ctrlSel   = cs && (wordAddr == ctrlAddr);
    assign statusSel = cs && (wordAddr == statusAddr);

    assign holdStats  = statusSel;
    assign statusRead = !cs && statusSeen;     // First cycle after cs falls

    // Byte lanes 0 and 1 are the only writable ones
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            control <= ctrlReset;
        end else if (ctrlSel) begin
            if (byteEn[0]) begin
                control[7:0] <= dataIn[7:0];   // Interleave, spare, rIndex
            end
            if (byteEn[1]) begin
                control[15:8] <= dataIn[15:8]; // Fill
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            statusSeen <= 1'b0;
        end else if (!cs) begin
            statusSeen <= 1'b0;                // Cleared together with the counters
        end else if (statusSel) begin
            statusSeen <= 1'b1;
        end
    end

    always_comb begin
        dataOut = 32'd0;                       // Idle bus and unmapped words read 0
        if (ctrlSel) begin
            dataOut = {16'd0, control};
        end else if (statusSel) begin
            dataOut = status;
        end
    end

endmodule

// File: verilog/rsStatsTop.sv
module rsStatsTop #(
    parameter int fifoDepth = rsStatsPkg::fifoDepth
) (
    input  logic                 busClk,
    input  logic                 rstN,
    input  logic                 cwValid,      // From the decoder core
    input  rsStatsPkg::cwResultT cwResult,
    input  logic                 cs,
    input  logic [4:0]           addr,
    input  logic [31:0]          dataIn,
    input  logic [3:0]           byteEn,
    output logic [31:0]          dataOut,
    output rsStatsPkg::rsCtrlT   control,      // To the decoder core
    output logic                 fifoOverflow
);
    import rsStatsPkg::*;

    logic     sumValid;
    frameSumT sumData;
    logic     popValid;
    frameSumT popData;
    statusT   status;
    logic     statusRead;
    logic     holdStats;

    rsFrameAssembler i_rsFrameAssembler (
        .busClk   (busClk),
        .rstN     (rstN),
        .cwValid  (cwValid),
        .cwResult (cwResult),
        .control  (control),
        .sumValid (sumValid),
        .sumData  (sumData)
    );

    // Holds summaries while the status word is being read
    rsSummaryFifo #(
        .payloadT (frameSumT),
        .depth    (fifoDepth)
    ) i_rsSummaryFifo (
        .busClk    (busClk),
        .rstN      (rstN),
        .pushValid (sumValid),
        .pushData  (sumData),
        .holdStats (holdStats),
        .popValid  (popValid),
        .popData   (popData),
        .overflow  (fifoOverflow)
    );

    rsStatsCounters i_rsStatsCounters (
        .busClk     (busClk),
        .rstN       (rstN),
        .popValid   (popValid),
        .popData    (popData),
        .statusRead (statusRead),
        .status     (status)
    );

    rsRegs i_rsRegs (
        .busClk     (busClk),
        .rstN       (rstN),
        .cs         (cs),
        .addr       (addr),
        .dataIn     (dataIn),
        .byteEn     (byteEn),
        .status     (status),
        .dataOut    (dataOut),
        .control    (control),
        .statusRead (statusRead),
        .holdStats  (holdStats)
    );

endmodule

// File: sim/rsStatsTb.sv
module rsStatsTb;
    import rsStatsPkg::*;

    localparam int tbFifoDepth = 4;
    localparam int satFrames   = 300;             // Enough to saturate the 8 bit counters
    localparam int bigFrames   = 520;             // 520 frames of 128 symbols pass 16'hFFFF
    localparam int totalCw     = 20 + 12 + 16 + 5 + satFrames + bigFrames * 8
                                 + 3 + tbFifoDepth + 2;
    localparam int watchdogCycles = totalCw + 600; // Bus accesses, drains and reset on top

    logic        busClk;
    logic        rstN;
    logic        cwValid;
    cwResultT    cwResult;
    logic        cs;
    logic [4:0]  addr;
    logic [31:0] dataIn;
    logic [3:0]  byteEn;
    logic [31:0] dataOut;
    rsCtrlT      control;
    logic        fifoOverflow;

    int statusErrs = 0;
    int ctrlErrs   = 0;
    int dataErrs   = 0;
    int otherErrs  = 0;
    int popCount   = 0;                           // Summaries taken by the counters
    int popTarget  = 0;                           // Summaries expected so far
    int expFrames  = 0;                           // Reference totals since the last read
    int expFails   = 0;
    int expErrs    = 0;

    rsStatsTop #(
        .fifoDepth (tbFifoDepth)
    ) i_rsStatsTop (
        .busClk       (busClk),
        .rstN         (rstN),
        .cwValid      (cwValid),
        .cwResult     (cwResult),
        .cs           (cs),
        .addr         (addr),
        .dataIn       (dataIn),
        .byteEn       (byteEn),
        .dataOut      (dataOut),
        .control      (control),
        .fifoOverflow (fifoOverflow)
    );

    initial begin
        busClk = 1'b0;
        forever begin
            #50 busClk = ~busClk;
        end
    end

    // Counters update on the edge where popValid is seen high
    always @(posedge busClk) begin
        if (rstN && i_rsStatsTop.popValid) begin
            popCount <= popCount + 1;
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge busClk);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("Some tests failed");
        $finish;
    end

    task automatic compareStatus(input string name, input statusT got, input statusT exp);
        if (got !== exp) begin
            statusErrs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareCtrl(input string name, input rsCtrlT got, input rsCtrlT exp);
        if (got !== exp) begin
            ctrlErrs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compareData(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            dataErrs++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // One codeword result, strobe lasts one cycle
    task automatic sendCw(input logic [7:0] errors, input logic fail);
        cwValid         = 1'b1;
        cwResult.errors = errors;
        cwResult.fail   = fail;
        @(posedge busClk);
        #10;
        cwValid = 1'b0;
    endtask

    task automatic writeWord(input logic [4:0] a, input logic [31:0] d, input logic [3:0] be);
        cs     = 1'b1;
        addr   = a;
        dataIn = d;
        byteEn = be;
        @(posedge busClk);
        #10;
        cs     = 1'b0;
        byteEn = 4'h0;
    endtask

    task automatic readWord(input logic [4:0] a, output logic [31:0] d);
        cs     = 1'b1;
        addr   = a;
        byteEn = 4'h0;
        @(posedge busClk);
        #10;
        d  = dataOut;                             // Stable, pops are frozen by the access
        cs = 1'b0;
        @(posedge busClk);                        // Clear edge for a status access
        #10;
    endtask

    task automatic setDepth(input logic [3:0] depth, input logic rIndex);
        rsCtrlT exp;
        exp = rsCtrlT'({8'h00, depth, 3'b000, rIndex});
        writeWord({ctrlAddr, 2'b00}, {16'd0, exp}, 4'b0011);
        compareCtrl("control", control, exp);
    endtask

    // Sends whole frames, only the first kept frames enter the reference totals
    task automatic sendFrames(input int depth, input int frames, input int kept,
                              input int minErr, input int maxErr, input int failOdds);
        int         f;
        int         c;
        int         errSum;
        logic       failed;
        logic [7:0] errors;
        logic       fail;
        for (f = 0; f < frames; f++) begin
            errSum = 0;
            failed = 1'b0;
            for (c = 0; c < depth; c++) begin
                errors = 8'($urandom_range(maxErr, minErr));
                fail   = (failOdds > 0) && ($urandom_range(failOdds - 1, 0) == 0);
                if (!fail) begin
                    errSum += int'(errors);       // Failed codewords add nothing
                end
                failed = failed | fail;
                sendCw(errors, fail);
            end
            if (f < kept) begin
                expFrames++;
                expErrs += errSum;
                if (failed) begin
                    expFails++;
                end
            end
        end
    endtask

    task automatic waitFrames(input int frames);
        int waited;
        popTarget += frames;
        waited = 0;
        while ((popCount < popTarget) && (waited < 50)) begin
            @(posedge busClk);
            #10;
            waited++;
        end
        if (popCount < popTarget) begin
            otherErrs++;
            $display("Timeout: only %0d of %0d frame summaries reached the counters",
                     popCount, popTarget);
        end
    endtask

    // Reads the status word and compares it with the saturated reference totals
    task automatic checkStatusRead(input string name);
        logic [31:0] d;
        statusT      exp;
        exp.failCnt  = (expFails > 255) ? 8'hFF : 8'(expFails);
        exp.frameCnt = (expFrames > 255) ? 8'hFF : 8'(expFrames);
        exp.errCnt   = (expErrs > 65535) ? 16'hFFFF : 16'(expErrs);
        readWord({statusAddr, 2'b00}, d);
        compareStatus(name, statusT'(d), exp);
        expFrames = 0;                            // Read clears the counters
        expFails  = 0;
        expErrs   = 0;
    endtask

    task automatic testReset();
        logic [31:0] d;
        compareCtrl("control", control, 16'h0010);
        readWord({ctrlAddr, 2'b00}, d);
        compareData("dataOut", d, 32'h0000_0010);
        checkStatusRead("status after reset");
        writeWord({ctrlAddr, 2'b00}, 32'h0000_A500, 4'b0010); // Fill lane only
        compareCtrl("control", control, 16'hA510);
        writeWord({ctrlAddr, 2'b00}, 32'hFFFF_FF21, 4'b0001); // Depth 2, rIndex 1
        compareCtrl("control", control, 16'hA521);
        writeWord({ctrlAddr, 2'b00}, 32'h1234_5678, 4'b1100); // Upper lanes not writable
        compareCtrl("control", control, 16'hA521);
        readWord({ctrlAddr, 2'b00}, d);
        compareData("dataOut", d, 32'h0000_A521);
        readWord(5'h08, d);
        compareData("dataOut", d, 32'h0);
        readWord(5'h1F, d);
        compareData("dataOut", d, 32'h0);
        setDepth(4'd1, 1'b0);
    endtask

    task automatic testDepthOne();
        setDepth(4'd1, 1'b0);
        sendFrames(1, 20, 20, 0, 8, 3);
        waitFrames(20);
        checkStatusRead("status depth 1");
        checkStatusRead("status second read");   // Nothing new since the clear
    endtask

    task automatic testDepths();
        setDepth(4'd4, 1'b0);
        sendFrames(4, 3, 3, 0, 8, 6);
        waitFrames(3);
        checkStatusRead("status depth 4");
        setDepth(4'd8, 1'b0);
        sendFrames(8, 2, 2, 0, 8, 10);
        waitFrames(2);
        checkStatusRead("status depth 8");
        setDepth(4'd6, 1'b0);                     // Illegal depth runs as 1
        sendFrames(1, 5, 5, 0, 8, 2);
        waitFrames(5);
        checkStatusRead("status depth 6");
    endtask

    task automatic testSaturation();
        setDepth(4'd1, 1'b0);
        sendFrames(1, satFrames, satFrames, 0, 8, 1);
        waitFrames(satFrames);
        checkStatusRead("status fail saturation");
        setDepth(4'd8, 1'b1);                     // E is 16, 128 symbols per frame
        sendFrames(8, bigFrames, bigFrames, 16, 16, 0);
        waitFrames(bigFrames);
        checkStatusRead("status error saturation");
        setDepth(4'd1, 1'b0);
    endtask

    // Frames sent while cs sits on the status word wait in the FIFO
    task automatic holdAndSend(input int frames, input int kept);
        cs     = 1'b1;
        addr   = {statusAddr, 2'b00};
        byteEn = 4'h0;
        @(posedge busClk);
        #10;
        sendFrames(1, frames, kept, 0, 8, 3);
        repeat (3) @(posedge busClk);
        #10;
        compareStatus("status while held", statusT'(dataOut), '0);
        cs = 1'b0;
        @(posedge busClk);
        #10;
        waitFrames(kept);
        checkStatusRead("status after hold");
    endtask

    task automatic testHold();
        holdAndSend(3, 3);
        compareData("fifoOverflow", {31'd0, fifoOverflow}, 32'd0);
        holdAndSend(tbFifoDepth + 2, tbFifoDepth); // Last two are dropped
        compareData("fifoOverflow", {31'd0, fifoOverflow}, 32'd1);
    endtask

    initial begin
        int totalErrs;
        void'($urandom(32'hee03));
        rstN     = 1'b0;
        cwValid  = 1'b0;
        cwResult = '0;
        cs       = 1'b0;
        addr     = 5'd0;
        dataIn   = 32'd0;
        byteEn   = 4'h0;
        repeat (10) @(posedge busClk);
        #10;
        rstN = 1'b1;

        testReset();
        testDepthOne();
        testDepths();
        testSaturation();
        testHold();

        totalErrs = statusErrs + ctrlErrs + dataErrs + otherErrs;
        $display("Errors: status %0d, control %0d, data %0d, other %0d",
                 statusErrs, ctrlErrs, dataErrs, otherErrs);
        if (totalErrs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: rsStats.f
verilog/rsStatsPkg.sv
verilog/rsFrameAssembler.sv
verilog/rsSummaryFifo.sv
verilog/rsStatsCounters.sv
verilog/rsRegs.sv
verilog/rsStatsTop.sv
sim/rsStatsTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rsStatsTb \
    -f rsStats.f -o rsStatsSim || { echo "Compile failed"; exit 1; }
./obj_dir/rsStatsSim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
